/* project.f */
+incdir+testbench
common/cpu_isa_pkg.sv
common/cpu_bus_pkg.sv
core/alu8.sv
core/register_file.sv
core/fetch_unit.sv
core/execute_unit.sv
src/mem_bank_split.sv
src/cpu_top.sv
testbench/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpu_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// instruction-level model, runs on model_mem and records every store
logic [7:0] model_mem [0:65535];
logic [15:0] m_pc;
logic [7:0] m_x;
logic [7:0] m_y;
logic [7:0] m_z;
flags_t m_flags;
logic [15:0] exp_addr [$];
logic [7:0] exp_data [$];

function automatic int signed8(input logic [7:0] v);
	return $signed(v);
endfunction

function automatic logic overflows(input int v);
	return v > 127 || v < -128;
endfunction

task automatic model_add(input logic [7:0] a, input logic [7:0] b, input int cin,
	output logic [7:0] r);
	int total;
	total = int'(a) + int'(b) + cin;
	r = 8'(total);
	m_flags.c = total > 255;
	m_flags.h = (int'(a & 8'h0f) + int'(b & 8'h0f) + cin) > 15;
	m_flags.o = overflows(signed8(a) + signed8(b) + cin);
	m_flags.z = r == 8'h00;
	m_flags.n = r[7];
endtask

// carry set means no borrow
task automatic model_sub(input logic [7:0] a, input logic [7:0] b, input int borrow,
	output logic [7:0] r);
	int total;
	total = int'(a) - int'(b) - borrow;
	r = 8'(total);
	m_flags.c = total >= 0;
	m_flags.h = (int'(a & 8'h0f) - int'(b & 8'h0f) - borrow) >= 0;
	m_flags.o = overflows(signed8(a) - signed8(b) - borrow);
	m_flags.z = r == 8'h00;
	m_flags.n = r[7];
endtask

task automatic model_logic(input logic [7:0] r);
	m_x = r;
	m_flags.z = r == 8'h00;
	m_flags.n = r[7];
endtask

task automatic model_run(input int max_steps);
	logic [7:0] op;
	logic [7:0] b1;
	logic [7:0] b;
	logic [7:0] discard;
	logic [15:0] dir;
	logic taken;
	int steps;
	bit done;
	m_pc = RESET_PC;
	m_flags = '0;
	exp_addr.delete();
	exp_data.delete();
	steps = 0;
	done = 0;
	while (!done && steps < max_steps)
	begin
		op = model_mem[m_pc];
		b1 = model_mem[m_pc + 16'd1];
		dir = {model_mem[m_pc + 16'd2], b1};
		steps++;
		if (op[7:5] == 3'b000)
		begin
			case (op[1:0])
				2'd0: b = b1;
				2'd1: b = model_mem[dir];
				2'd2: b = m_y;
				default: b = m_z;
			endcase
			m_pc += (op[1:0] == 2'd0) ? 16'd2 : (op[1:0] == 2'd1) ? 16'd3 : 16'd1;
			case (op[4:2])
				3'd0: model_add(m_x, b, 0, m_x);
				3'd1: model_add(m_x, b, int'(m_flags.c), m_x);
				3'd2: model_sub(m_x, b, 0, m_x);
				3'd3: model_sub(m_x, b, int'(!m_flags.c), m_x);
				3'd4: model_sub(m_x, b, 0, discard);
				3'd5: model_logic(m_x & b);
				3'd6: model_logic(m_x | b);
				default: model_logic(m_x ^ b);
			endcase
		end
		else
		begin
			case (op)
				OP_INC_XL: model_add(m_x, 8'h01, 0, m_x);
				OP_DEC_XL: model_sub(m_x, 8'h01, 0, m_x);
				OP_LD_XL_IMM: model_logic(b1);
				OP_LD_XL_DIR: model_logic(model_mem[dir]);
				OP_LD_DIR_XL:
				begin
					model_mem[dir] = m_x;
					exp_addr.push_back(dir);
					exp_data.push_back(m_x);
				end
				OP_LD_XL_YL: m_x = m_y;
				OP_LD_XL_ZL: m_x = m_z;
				OP_LD_YL_XL: m_y = m_x;
				OP_LD_ZL_XL: m_z = m_x;
				OP_TRAP: done = 1;
				default: ;
			endcase
			case (op)
				OP_INC_XL, OP_DEC_XL, OP_NOP, OP_LD_XL_YL, OP_LD_XL_ZL,
				OP_LD_YL_XL, OP_LD_ZL_XL: m_pc += 16'd1;
				OP_LD_XL_IMM: m_pc += 16'd2;
				OP_LD_XL_DIR, OP_LD_DIR_XL: m_pc += 16'd3;
				OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
				begin
					case (op)
						OP_JR: taken = 1'b1;
						OP_JRZ: taken = m_flags.z;
						OP_JRNZ: taken = !m_flags.z;
						OP_JRC: taken = m_flags.c;
						default: taken = !m_flags.c;
					endcase
					// target is relative to the branch's own address
					m_pc = taken ? m_pc + {{8{b1[7]}}, b1} : m_pc + 16'd2;
				end
				default: ;
			endcase
		end
	end
endtask

`endif

/* testbench/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	logic clk = 1'b0;
	logic reset;
	bank_rd_t even_rd;
	bank_rd_t odd_rd;
	logic [7:0] even_rd_data;
	logic [7:0] odd_rd_data;
	bank_wr_t even_wr;
	bank_wr_t odd_wr;
	logic trap;

	logic [7:0] even_mem [0:32767];
	logic [7:0] odd_mem [0:32767];
	logic [14:0] even_addr_q;
	logic [14:0] odd_addr_q;
	logic [7:0] prog [$];
	logic [31:0] lfsr;
	int errors;
	int checks;
	int tests;
	int cycle_count;
	int cycle_limit;
	bit running;

	`include "cpu_model.svh"

	cpu_top u_cpu_top
	(
		.clk(clk),
		.reset(reset),
		.even_rd(even_rd),
		.odd_rd(odd_rd),
		.even_rd_data(even_rd_data),
		.odd_rd_data(odd_rd_data),
		.even_wr(even_wr),
		.odd_wr(odd_wr),
		.trap(trap)
	);

	always #4 clk = ~clk;

	// synchronous banks with read data one cycle after the address
	always @(posedge clk)
	begin
		if (even_wr.en === 1'b1)
			even_mem[even_wr.addr] = even_wr.data;
		if (odd_wr.en === 1'b1)
			odd_mem[odd_wr.addr] = odd_wr.data;
		even_addr_q = even_rd.addr;
		odd_addr_q = odd_rd.addr;
		#1;
		even_rd_data = even_mem[even_addr_q];
		odd_rd_data = odd_mem[odd_addr_q];
	end

	always @(negedge clk)
	begin
		if (running)
		begin
			cycle_count++;
			if (cycle_count > cycle_limit)
			begin
				$display("timeout: trap not reached after %0d cycles", cycle_count);
				$display("Errors found");
				$finish;
			end
		end
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [7:0] fill_byte(input logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'h3c;
	endfunction

	function automatic logic [15:0] rand_dir();
		return {8'h80, 8'(rand_bits(8))};
	endfunction

	task automatic emit1(input logic [7:0] op);
		prog.push_back(op);
	endtask

	task automatic emit2(input logic [7:0] op, input logic [7:0] b);
		prog.push_back(op);
		prog.push_back(b);
	endtask

	task automatic emit3(input logic [7:0] op, input logic [15:0] a);
		prog.push_back(op);
		prog.push_back(a[7:0]);
		prog.push_back(a[15:8]);
	endtask

	task automatic gen_program(input int kind);
		logic [7:0] op;
		int off;
		prog.delete();
		// registers come up unknown
		emit2(OP_LD_XL_IMM, 8'(rand_bits(8)));
		emit1(OP_LD_YL_XL);
		emit2(OP_LD_XL_IMM, 8'(rand_bits(8)));
		emit1(OP_LD_ZL_XL);
		emit2(OP_LD_XL_IMM, 8'(rand_bits(8)));
		repeat (12)
		begin
			if (kind == 0)
			begin
				if (rand_bits(3) == 0)
					emit1(rand_bits(1) ? OP_INC_XL : OP_DEC_XL);
				else
				begin
					op = {3'b000, 3'(rand_bits(3)), 2'(rand_bits(2))};
					if (op[1:0] == 2'd0)
						emit2(op, 8'(rand_bits(8)));
					else if (op[1:0] == 2'd1)
						emit3(op, rand_dir());
					else
						emit1(op);
				end
				emit3(OP_LD_DIR_XL, rand_dir());
				if (rand_bits(2) == 0)
					emit1(rand_bits(1) ? OP_LD_YL_XL : OP_LD_ZL_XL);
			end
			else if (kind == 1)
			begin
				op = 8'(rand_bits(8));
				emit3(OP_LD_DIR_XL, {8'h80, op});
				emit2(OP_LD_XL_IMM, 8'(rand_bits(8)));
				emit3(OP_LD_XL_DIR, {8'h80, op});
				emit3(OP_LD_DIR_XL, rand_dir());
				emit1(OP_INC_XL);
			end
			else
			begin
				emit2({3'b000, 3'(rand_bits(3)), 2'b00}, 8'(rand_bits(8)));
				emit3(OP_LD_DIR_XL, rand_dir());
				emit2(8'(OP_JR) + 8'(rand_bits(3) % 5), 8'(2 + rand_bits(3) % 5));
				off = int'(prog[prog.size() - 1]);
				// a taken branch skips everything up to the target
				if (off >= 5)
				begin
					emit3(OP_LD_DIR_XL, rand_dir());
					repeat (off - 5)
						emit1(OP_INC_XL);
				end
				else
				begin
					repeat (off - 2)
						emit1(OP_INC_XL);
				end
				emit3(OP_LD_DIR_XL, rand_dir());
			end
		end
		emit1(OP_TRAP);
	endtask

	task automatic build_image(input int kind);
		gen_program(kind);
		for (int a = 0; a < 65536; a++)
			model_mem[a] = fill_byte(16'(a));
		foreach (prog[i])
			model_mem[RESET_PC + 16'(i)] = prog[i];
		for (int a = 0; a < 32768; a++)
		begin
			even_mem[a] = model_mem[2 * a];
			odd_mem[a] = model_mem[2 * a + 1];
		end
		model_run(4 * prog.size());
	endtask

	task automatic check_idle();
		assert (even_wr.en === 1'b0 && odd_wr.en === 1'b0 && trap === 1'b0)
		else
		begin
			errors++;
			$display("write enable or trap active during reset at %0t", $time);
		end
	endtask

	task automatic check_write(input logic en, input logic [15:0] addr, input logic [7:0] data,
		input bit after_trap, inout int seen);
		if (en === 1'b1)
		begin
			assert (!after_trap && seen < exp_addr.size())
			else
			begin
				errors++;
				$display("unexpected write of %h to %h at %0t", data, addr, $time);
			end
			if (!after_trap && seen < exp_addr.size())
			begin
				assert (addr == exp_addr[seen] && data == exp_data[seen])
				else
				begin
					errors++;
					$display("mismatch at %0t: write %h to %h, expected %h to %h",
						$time, data, addr, exp_data[seen], exp_addr[seen]);
				end
				seen++;
			end
		end
	endtask

	task automatic run_program(input int kind, input string name);
		int seen;
		int quiet;
		int err_before;
		bit trapped;
		err_before = errors;
		seen = 0;
		quiet = 0;
		trapped = 0;
		build_image(kind);
		@(posedge clk);
		#1;
		reset = 1'b1;
		repeat (2)
		begin
			@(posedge clk);
			@(negedge clk);
			check_idle();
		end
		@(posedge clk);
		#1;
		reset = 1'b0;
		cycle_count = 0;
		cycle_limit = 3 * prog.size() + 50;
		running = 1;
		@(negedge clk);
		assert (even_rd.addr == RESET_PC[15:1] && odd_rd.addr == RESET_PC[15:1])
		else
		begin
			errors++;
			$display("mismatch at %0t: first read at bank words %h and %h, expected %h",
				$time, even_rd.addr, odd_rd.addr, RESET_PC[15:1]);
		end
		while (!trapped || quiet < 20)
		begin
			check_write(even_wr.en, {even_wr.addr, 1'b0}, even_wr.data, trapped, seen);
			check_write(odd_wr.en, {odd_wr.addr, 1'b1}, odd_wr.data, trapped, seen);
			if (trapped)
			begin
				assert (trap === 1'b1)
				else
				begin
					errors++;
					$display("trap dropped at %0t", $time);
				end
				quiet++;
			end
			else if (trap === 1'b1)
			begin
				trapped = 1;
				running = 0;
				assert (seen == exp_addr.size())
				else
				begin
					errors++;
					$display("mismatch at %0t: %0d writes before trap, model made %0d",
						$time, seen, exp_addr.size());
				end
			end
			@(negedge clk);
		end
		checks += seen;
		tests++;
		$display("test %s: %0d bytes, %0d writes checked, %0d errors",
			name, prog.size(), seen, errors - err_before);
	endtask

	initial
	begin
		reset = 1'b1;
		even_rd_data = 8'h00;
		odd_rd_data = 8'h00;
		lfsr = 32'h164787d6;
		errors = 0;
		checks = 0;
		tests = 0;
		running = 0;
		cycle_count = 0;
		cycle_limit = 0;
		run_program(0, "alu");
		run_program(1, "load_store");
		run_program(2, "branch");
		$display("%0d tests, %0d writes checked, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top
(
	input logic clk,
	input logic reset,
	output cpu_bus_pkg::bank_rd_t even_rd,
	output cpu_bus_pkg::bank_rd_t odd_rd,
	input logic [7:0] even_rd_data,
	input logic [7:0] odd_rd_data,
	output cpu_bus_pkg::bank_wr_t even_wr,
	output cpu_bus_pkg::bank_wr_t odd_wr,
	output logic trap
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	mem_rd_t rd_req;
	logic [15:0] rd_word;
	mem_wr_t mem_wr;
	reg_wr_t reg_wr;
	logic execute;
	logic [23:0] inst;
	logic [15:0] operand;
	logic branch_taken;
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] z;
	flags_t flags;
	flags_t next_flags;

	fetch_unit u_fetch_unit (.*);

	execute_unit u_execute_unit (.*);

	register_file u_register_file (.*);

	mem_bank_split u_mem_bank_split
	(
		.wr_req(mem_wr),
		.*
	);

endmodule

/* src/mem_bank_split.sv */
`timescale 1ns/1ns

module mem_bank_split
(
	input logic clk,
	input cpu_bus_pkg::mem_rd_t rd_req,
	output logic [15:0] rd_word,
	output cpu_bus_pkg::bank_rd_t even_rd,
	output cpu_bus_pkg::bank_rd_t odd_rd,
	input logic [7:0] even_rd_data,
	input logic [7:0] odd_rd_data,
	input cpu_bus_pkg::mem_wr_t wr_req,
	output cpu_bus_pkg::bank_wr_t even_wr,
	output cpu_bus_pkg::bank_wr_t odd_wr
);
	import cpu_bus_pkg::*;

	logic [BANK_ADDR_W-1:0] rd_base;
	logic [BANK_ADDR_W-1:0] wr_base;
	// low address bit of the data arriving this cycle
	logic rd_odd_q;

	// odd start: low byte sits in the odd bank, high byte in the next even word
	assign rd_base = rd_req.addr[ADDR_W-1:1];
	assign odd_rd.addr = rd_base;
	assign even_rd.addr = rd_base + BANK_ADDR_W'(rd_req.addr[0]);

	always_ff @(posedge clk)
		rd_odd_q <= rd_req.addr[0];

	assign rd_word = rd_odd_q ? {even_rd_data, odd_rd_data} : {odd_rd_data, even_rd_data};

	assign wr_base = wr_req.addr[ADDR_W-1:1];
	assign odd_wr.addr = wr_base;
	assign even_wr.addr = wr_base + BANK_ADDR_W'(wr_req.addr[0]);
	assign even_wr.data = wr_req.addr[0] ? wr_req.data[15:8] : wr_req.data[7:0];
	assign odd_wr.data = wr_req.addr[0] ? wr_req.data[7:0] : wr_req.data[15:8];
	assign even_wr.en = wr_req.addr[0] ? wr_req.be[1] : wr_req.be[0];
	assign odd_wr.en = wr_req.addr[0] ? wr_req.be[0] : wr_req.be[1];

endmodule

/* core/execute_unit.sv */
`timescale 1ns/1ns

module execute_unit
(
	input logic execute,
	input logic [23:0] inst,
	input logic [15:0] operand,
	input logic [15:0] x,
	input logic [15:0] y,
	input logic [15:0] z,
	input cpu_isa_pkg::flags_t flags,
	output cpu_isa_pkg::flags_t next_flags,
	output cpu_bus_pkg::reg_wr_t reg_wr,
	output cpu_bus_pkg::mem_wr_t mem_wr,
	output logic branch_taken,
	output logic trap
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	opcode_t opcode;
	alu_op_t alu_op;
	alu_src_t src;
	logic [7:0] alu_b;
	logic [7:0] alu_result;
	flags_t alu_flags;

	assign opcode = opcode_t'(inst[7:0]);

	// xl is always the first alu operand
	always_comb
	begin
		alu_op = ALU_PASS;
		src = SRC_IMM;
		if (is_alu_group(opcode))
		begin
			alu_op = group_alu_op(opcode);
			src = alu_src(opcode);
		end
		else if (opcode == OP_INC_XL)
			alu_op = ALU_INC;
		else if (opcode == OP_DEC_XL)
			alu_op = ALU_DEC;
		else if (opcode == OP_LD_XL_DIR)
			src = SRC_DIR;
		case (src)
			SRC_IMM: alu_b = inst[15:8];
			SRC_DIR: alu_b = operand[7:0];
			SRC_YL: alu_b = y[7:0];
			default: alu_b = z[7:0];
		endcase
	end

	alu8 u_alu8
	(
		.op(alu_op),
		.a(x[7:0]),
		.b(alu_b),
		.flags_in(flags),
		.result(alu_result),
		.flags_out(alu_flags)
	);

	always_comb
	begin
		reg_wr.idx = REG_X;
		reg_wr.data = {alu_result, alu_result};
		reg_wr.be = 2'b00;
		mem_wr.addr = inst[23:8];
		mem_wr.data = {8'h00, x[7:0]};
		mem_wr.be = 2'b00;
		next_flags = flags;
		branch_taken = 1'b0;
		trap = 1'b0;
		if (execute)
		begin
			if (uses_alu(opcode))
			begin
				next_flags = alu_flags;
				// compare keeps xl
				if (!is_compare(opcode))
					reg_wr.be = 2'b01;
			end
			else
			begin
				case (opcode)
					OP_LD_XL_YL:
					begin
						reg_wr.data = {y[7:0], y[7:0]};
						reg_wr.be = 2'b01;
					end
					OP_LD_XL_ZL:
					begin
						reg_wr.data = {z[7:0], z[7:0]};
						reg_wr.be = 2'b01;
					end
					OP_LD_YL_XL:
					begin
						reg_wr.idx = REG_Y;
						reg_wr.data = {x[7:0], x[7:0]};
						reg_wr.be = 2'b01;
					end
					OP_LD_ZL_XL:
					begin
						reg_wr.idx = REG_Z;
						reg_wr.data = {x[7:0], x[7:0]};
						reg_wr.be = 2'b01;
					end
					OP_LD_DIR_XL: mem_wr.be = 2'b01;
					OP_JR: branch_taken = 1'b1;
					OP_JRZ: branch_taken = flags[FLAG_Z];
					OP_JRNZ: branch_taken = !flags[FLAG_Z];
					OP_JRC: branch_taken = flags[FLAG_C];
					OP_JRNC: branch_taken = !flags[FLAG_C];
					OP_TRAP: trap = 1'b1;
					default: trap = 1'b0;
				endcase
			end
		end
	end

endmodule

/* core/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit
(
	input logic clk,
	input logic reset,
	output cpu_bus_pkg::mem_rd_t rd_req,
	input logic [15:0] rd_word,
	output logic execute,
	output logic [23:0] inst,
	output logic [15:0] operand,
	input logic branch_taken,
	input logic trap
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] next_pc;
	logic [23:0] inst_q;
	logic upper_valid;
	logic operand_pending;
	// low until the first read after reset has returned
	logic primed;
	opcode_t opcode;
	logic loading_upper;
	logic loading_operand;

	// upper byte comes from a read at pc+1, so it is the high byte of the word
	always_comb
	begin
		if (upper_valid)
			inst = {rd_word[15:8], inst_q[15:0]};
		else if (operand_pending)
			inst = inst_q;
		else
			inst = {8'h00, rd_word};
	end

	assign operand = rd_word;
	assign opcode = opcode_t'(inst[7:0]);

	assign loading_upper = primed && loads_upper(opcode) && !upper_valid && !operand_pending;
	assign loading_operand = primed && loads_operand(opcode) && !loading_upper &&
		!operand_pending;
	assign execute = primed && !loading_upper && !loading_operand;

	always_comb
	begin
		if (!execute || trap)
			next_pc = pc;
		else if (branch_taken)
			next_pc = pc + {{8{inst[15]}}, inst[15:8]};
		else
			next_pc = pc + {14'd0, inst_size(opcode)};
	end

	always_comb
	begin
		if (loading_upper)
			rd_req.addr = pc + 16'd1;
		else if (loading_operand)
			rd_req.addr = inst[23:8];
		else
			rd_req.addr = next_pc;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= RESET_PC;
			upper_valid <= 1'b0;
			operand_pending <= 1'b0;
			primed <= 1'b0;
		end
		else
		begin
			pc <= next_pc;
			upper_valid <= loading_upper;
			operand_pending <= loading_operand;
			primed <= 1'b1;
		end
	end

	always_ff @(posedge clk)
		inst_q <= inst;

endmodule

/* core/register_file.sv */
`timescale 1ns/1ns

module register_file
(
	input logic clk,
	input logic reset,
	input cpu_bus_pkg::reg_wr_t reg_wr,
	input cpu_isa_pkg::flags_t next_flags,
	output logic [15:0] x,
	output logic [15:0] y,
	output logic [15:0] z,
	output cpu_isa_pkg::flags_t flags
);
	import cpu_bus_pkg::*;

	logic [15:0] regs [3];

	// byte lanes written independently
	always_ff @(posedge clk)
	begin
		if (reg_wr.be[0])
			regs[reg_wr.idx][7:0] <= reg_wr.data[7:0];
		if (reg_wr.be[1])
			regs[reg_wr.idx][15:8] <= reg_wr.data[15:8];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	assign x = regs[REG_X];
	assign y = regs[REG_Y];
	assign z = regs[REG_Z];

endmodule

/* core/alu8.sv */
`timescale 1ns/1ns

module alu8
(
	input cpu_isa_pkg::alu_op_t op,
	input logic [7:0] a,
	input logic [7:0] b,
	input cpu_isa_pkg::flags_t flags_in,
	output logic [7:0] result,
	output cpu_isa_pkg::flags_t flags_out
);
	import cpu_isa_pkg::*;

	always_comb
	begin
		logic [7:0] addend;
		logic carry_in;
		logic [8:0] sum;
		logic [4:0] half;
		logic arith;

		arith = 1'b1;
		addend = b;
		carry_in = 1'b0;
		// subtract is add of the complement, carry set means no borrow
		case (op)
			ALU_ADD: carry_in = 1'b0;
			ALU_ADC: carry_in = flags_in.c;
			ALU_SUB:
			begin
				addend = ~b;
				carry_in = 1'b1;
			end
			ALU_SBC:
			begin
				addend = ~b;
				carry_in = flags_in.c;
			end
			ALU_INC: addend = 8'h01;
			ALU_DEC:
			begin
				addend = 8'hfe;
				carry_in = 1'b1;
			end
			default: arith = 1'b0;
		endcase

		sum = {1'b0, a} + {1'b0, addend} + {8'd0, carry_in};
		half = {1'b0, a[3:0]} + {1'b0, addend[3:0]} + {4'd0, carry_in};

		flags_out = flags_in;
		if (arith)
		begin
			result = sum[7:0];
			flags_out.c = sum[8];
			flags_out.h = half[4];
			flags_out.o = (a[7] == addend[7]) && (sum[7] != a[7]);
		end
		else
		begin
			case (op)
				ALU_AND: result = a & b;
				ALU_OR: result = a | b;
				ALU_XOR: result = a ^ b;
				default: result = b;
			endcase
		end
		flags_out.z = (result == 8'h00);
		flags_out.n = result[7];
	end

endmodule

/* common/cpu_bus_pkg.sv */
package cpu_bus_pkg;

	localparam int ADDR_W = 16;
	localparam int BANK_ADDR_W = 15;

	// first fetch address after reset
	localparam logic [ADDR_W-1:0] RESET_PC = 16'h4000;

	localparam logic [1:0] REG_X = 2'd0;
	localparam logic [1:0] REG_Y = 2'd1;
	localparam logic [1:0] REG_Z = 2'd2;

	typedef struct packed
	{
		logic [ADDR_W-1:0] addr;
	} mem_rd_t;

	// be[0] covers the byte at addr, be[1] the one after it
	typedef struct packed
	{
		logic [ADDR_W-1:0] addr;
		logic [15:0] data;
		logic [1:0] be;
	} mem_wr_t;

	typedef struct packed
	{
		logic [BANK_ADDR_W-1:0] addr;
	} bank_rd_t;

	typedef struct packed
	{
		logic [BANK_ADDR_W-1:0] addr;
		logic [7:0] data;
		logic en;
	} bank_wr_t;

	typedef struct packed
	{
		logic [1:0] idx;
		logic [15:0] data;
		logic [1:0] be;
	} reg_wr_t;

endpackage

/* common/cpu_isa_pkg.sv */
package cpu_isa_pkg;

	// alu group: bits [4:2] pick the function, bits [1:0] the source
	typedef enum logic [7:0]
	{
		OP_ADD_IMM = 8'h00, OP_ADD_DIR = 8'h01, OP_ADD_YL = 8'h02, OP_ADD_ZL = 8'h03,
		OP_ADC_IMM = 8'h04, OP_ADC_DIR = 8'h05, OP_ADC_YL = 8'h06, OP_ADC_ZL = 8'h07,
		OP_SUB_IMM = 8'h08, OP_SUB_DIR = 8'h09, OP_SUB_YL = 8'h0a, OP_SUB_ZL = 8'h0b,
		OP_SBC_IMM = 8'h0c, OP_SBC_DIR = 8'h0d, OP_SBC_YL = 8'h0e, OP_SBC_ZL = 8'h0f,
		OP_CP_IMM = 8'h10, OP_CP_DIR = 8'h11, OP_CP_YL = 8'h12, OP_CP_ZL = 8'h13,
		OP_AND_IMM = 8'h14, OP_AND_DIR = 8'h15, OP_AND_YL = 8'h16, OP_AND_ZL = 8'h17,
		OP_OR_IMM = 8'h18, OP_OR_DIR = 8'h19, OP_OR_YL = 8'h1a, OP_OR_ZL = 8'h1b,
		OP_XOR_IMM = 8'h1c, OP_XOR_DIR = 8'h1d, OP_XOR_YL = 8'h1e, OP_XOR_ZL = 8'h1f,
		OP_INC_XL = 8'h20, OP_DEC_XL = 8'h21,
		OP_LD_XL_IMM = 8'h30, OP_LD_XL_DIR = 8'h31, OP_LD_DIR_XL = 8'h32,
		OP_LD_XL_YL = 8'h34, OP_LD_XL_ZL = 8'h35, OP_LD_YL_XL = 8'h36, OP_LD_ZL_XL = 8'h37,
		OP_JR = 8'h40, OP_JRZ = 8'h41, OP_JRNZ = 8'h42, OP_JRC = 8'h43, OP_JRNC = 8'h44,
		OP_NOP = 8'h60,
		OP_TRAP = 8'hff
	} opcode_t;

	typedef enum logic [2:0]
	{
		FLAG_H,
		FLAG_C,
		FLAG_N,
		FLAG_Z,
		FLAG_O
	} flag_idx_t;

	// bit order follows flag_idx_t
	typedef struct packed
	{
		logic o;
		logic z;
		logic n;
		logic c;
		logic h;
	} flags_t;

	typedef enum logic [3:0]
	{
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC,
		ALU_DEC,
		ALU_PASS
	} alu_op_t;

	typedef enum logic [1:0]
	{
		SRC_IMM,
		SRC_DIR,
		SRC_YL,
		SRC_ZL
	} alu_src_t;

	function automatic logic is_alu_group(opcode_t op);
		return op[7:5] == 3'b000;
	endfunction

	function automatic alu_src_t alu_src(opcode_t op);
		return alu_src_t'(op[1:0]);
	endfunction

	function automatic logic is_compare(opcode_t op);
		return is_alu_group(op) && op[4:2] == 3'd4;
	endfunction

	function automatic alu_op_t group_alu_op(opcode_t op);
		case (op[4:2])
			3'd0: return ALU_ADD;
			3'd1: return ALU_ADC;
			3'd2, 3'd4: return ALU_SUB;
			3'd3: return ALU_SBC;
			3'd5: return ALU_AND;
			3'd6: return ALU_OR;
			default: return ALU_XOR;
		endcase
	endfunction

	// everything whose xl result and flags come from the alu
	function automatic logic uses_alu(opcode_t op);
		return is_alu_group(op) ||
			op inside {OP_INC_XL, OP_DEC_XL, OP_LD_XL_IMM, OP_LD_XL_DIR};
	endfunction

	function automatic logic [1:0] inst_size(opcode_t op);
		if (is_alu_group(op))
			return (alu_src(op) == SRC_IMM) ? 2'd2 : (alu_src(op) == SRC_DIR) ? 2'd3 : 2'd1;
		else if (op inside {OP_LD_XL_DIR, OP_LD_DIR_XL})
			return 2'd3;
		else if (op inside {OP_LD_XL_IMM, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC})
			return 2'd2;
		else
			return 2'd1;
	endfunction

	function automatic logic loads_upper(opcode_t op);
		return inst_size(op) == 2'd3;
	endfunction

	function automatic logic loads_operand(opcode_t op);
		return (is_alu_group(op) && alu_src(op) == SRC_DIR) || op == OP_LD_XL_DIR;
	endfunction

endpackage
